// File: hw/biu_cfg.svh
/*
 * BIU configuration macros
 * bus widths, interrupt controller region code and order queue depth
 */
`ifndef BIU_CFG_SVH
`define BIU_CFG_SVH

// bus widths
`define BIU_ADDR_W        32    // icb, axi and ahb address
`define BIU_DATA_W        64    // internal and external data
`define BIU_JTAG_W        32    // debug port data
`define BIU_MASK_W        8     // one bit per data byte

// region decode
`define BIU_REGION_MSB_W  4     // top address bits that pick the target
`define BIU_INT_BASE      4'h9  // interrupt controller region

// commands in flight
`define BIU_QUEUE_DEPTH   4

`endif

// File: hw/biu_icb_pkg.sv
/*
 * internal command/response bus types
 * master and target enums, address, data and mask vectors
 */
`include "biu_cfg.svh"
`default_nettype none

package biu_icb_pkg;

  // issuing master, kept in the master order queue
  typedef enum logic {
    MASTER_JTAG = 1'b0,
    MASTER_LSU  = 1'b1
  } master_e;

  // response kind expected by a target queue slot
  typedef enum logic [1:0] {
    TGT_PAD_READ  = 2'd0,  // axi r channel
    TGT_PAD_WRITE = 2'd1,  // axi b channel
    TGT_INT       = 2'd2   // ahb held response
  } target_e;

  typedef logic [`BIU_ADDR_W-1:0] addr_t;
  typedef logic [`BIU_DATA_W-1:0] data_t;
  typedef logic [`BIU_MASK_W-1:0] mask_t;

endpackage

`default_nettype wire

// File: hw/biu_ext_pkg.sv
/*
 * external bus types
 * AXI response codes and AHB-lite transfer types
 */
`default_nettype none

package biu_ext_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,  // upper bit set means error
    DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_NONSEQ = 2'b10  // single transfer
  } htrans_e;

endpackage

`default_nettype wire

// File: hw/biu_icb_if.sv
/*
 * internal command/response bus
 * initiator and responder modports
 */
`default_nettype none

interface biu_icb_if;
  import biu_icb_pkg::*;

  // command channel
  logic    cmd_valid;
  logic    cmd_ready;
  addr_t   cmd_addr;
  logic    cmd_read;    // 1 read, 0 write
  data_t   cmd_wdata;
  mask_t   cmd_wmask;
  master_e cmd_master;

  // response channel
  logic    rsp_valid;
  logic    rsp_ready;
  logic    rsp_read;    // head slot expects read data
  data_t   rsp_rdata;
  logic    rsp_err;
  master_e rsp_master;

  modport initiator (
    output cmd_valid, cmd_addr, cmd_read, cmd_wdata, cmd_wmask, cmd_master,
    output rsp_ready, rsp_read,
    input  cmd_ready, rsp_valid, rsp_rdata, rsp_err, rsp_master
  );

  modport responder (
    input  cmd_valid, cmd_addr, cmd_read, cmd_wdata, cmd_wmask, cmd_master,
    input  rsp_ready, rsp_read,
    output cmd_ready, rsp_valid, rsp_rdata, rsp_err, rsp_master
  );

endinterface

`default_nettype wire

// File: hw/biu_arb.sv
/*
 * master side of the BIU
 * fixed priority command pick between jtag and lsu
 * jtag data widening and registered responses per master
 */
`include "biu_cfg.svh"
`default_nettype none

module biu_arb (
  input  wire logic                     clk,
  input  wire logic                     rstn,
  // jtag debug port
  input  wire logic                     jtag_cmd_valid,
  output logic                          jtag_cmd_ready,
  input  wire biu_icb_pkg::addr_t       jtag_cmd_addr,
  input  wire logic                     jtag_cmd_read,
  input  wire logic [`BIU_JTAG_W-1:0]   jtag_cmd_wdata,
  input  wire logic [`BIU_JTAG_W/8-1:0] jtag_cmd_wmask,
  output logic                          jtag_rsp_valid,
  output logic [`BIU_JTAG_W-1:0]        jtag_rsp_rdata,
  output logic                          jtag_rsp_err,
  // load/store unit
  input  wire logic                     lsu_cmd_valid,
  output logic                          lsu_cmd_ready,
  input  wire biu_icb_pkg::addr_t       lsu_cmd_addr,
  input  wire logic                     lsu_cmd_read,
  input  wire biu_icb_pkg::data_t       lsu_cmd_wdata,
  input  wire biu_icb_pkg::mask_t       lsu_cmd_wmask,
  output logic                          lsu_rsp_valid,
  output biu_icb_pkg::data_t            lsu_rsp_rdata,
  output logic                          lsu_rsp_err,
  biu_icb_if.initiator                  arb_bus
);
  import biu_icb_pkg::*;

  logic jtag_sel;  // jtag owns the command path
  logic jtag_hit;
  logic lsu_hit;

  // ---------------------------------------------------------------------
  // command pick
  // ---------------------------------------------------------------------
  assign jtag_sel = jtag_cmd_valid;  // jtag wins on a tie

  assign arb_bus.cmd_valid  = jtag_cmd_valid | lsu_cmd_valid;
  assign arb_bus.cmd_master = jtag_sel ? MASTER_JTAG : MASTER_LSU;
  assign arb_bus.cmd_addr   = jtag_sel ? jtag_cmd_addr : lsu_cmd_addr;
  assign arb_bus.cmd_read   = jtag_sel ? jtag_cmd_read : lsu_cmd_read;
  assign arb_bus.cmd_wdata  = jtag_sel ? data_t'(jtag_cmd_wdata) : lsu_cmd_wdata;  // low lanes
  assign arb_bus.cmd_wmask  = jtag_sel ? mask_t'(jtag_cmd_wmask) : lsu_cmd_wmask;

  assign jtag_cmd_ready = jtag_cmd_valid & arb_bus.cmd_ready;
  assign lsu_cmd_ready  = lsu_cmd_valid & ~jtag_cmd_valid & arb_bus.cmd_ready;  // lsu yields

  // ---------------------------------------------------------------------
  // response return
  // ---------------------------------------------------------------------
  assign jtag_hit = arb_bus.rsp_valid & (arb_bus.rsp_master == MASTER_JTAG);
  assign lsu_hit  = arb_bus.rsp_valid & (arb_bus.rsp_master == MASTER_LSU);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      jtag_rsp_valid <= 1'b0;
      lsu_rsp_valid  <= 1'b0;
    end else begin
      jtag_rsp_valid <= jtag_hit;  // one cycle pulse
      lsu_rsp_valid  <= lsu_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (jtag_hit) begin
      jtag_rsp_rdata <= arb_bus.rsp_rdata[`BIU_JTAG_W-1:0];  // low word only
      jtag_rsp_err   <= arb_bus.rsp_err;
    end
    if (lsu_hit) begin
      lsu_rsp_rdata <= arb_bus.rsp_rdata;
      lsu_rsp_err   <= arb_bus.rsp_err;
    end
  end

  // a waiting lsu command stays on the port until taken
  a_lsu_held: assert property (@(posedge clk) disable iff (!rstn)
    lsu_cmd_valid && !lsu_cmd_ready |=> lsu_cmd_valid && $stable(lsu_cmd_addr));

endmodule

`default_nettype wire

// File: hw/biu_order_ctrl.sv
/*
 * BIU ordering control
 * region decode onto the pad or int bus
 * master and target order queues and in-order response select
 */
`include "biu_cfg.svh"
`default_nettype none

module biu_order_ctrl (
  input  wire logic    clk,
  input  wire logic    rstn,
  biu_icb_if.responder arb_bus,
  biu_icb_if.initiator pad_bus,
  biu_icb_if.initiator int_bus
);
  import biu_icb_pkg::*;

  localparam int             DEPTH    = `BIU_QUEUE_DEPTH;
  localparam int             PTR_W    = $clog2(DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(DEPTH);

  logic             is_int;   // address in interrupt controller region
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;
  logic             pad_acc;
  logic             int_acc;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   cnt;      // commands in flight
  target_e          cmd_tgt;
  target_e          head_tgt;
  master_e          master_q [DEPTH];
  target_e          tgt_q    [DEPTH];

  // ---------------------------------------------------------------------
  // command decode
  // ---------------------------------------------------------------------
  assign is_int = arb_bus.cmd_addr[`BIU_ADDR_W-1 -: `BIU_REGION_MSB_W] == `BIU_INT_BASE;
  assign full   = cnt == FULL_CNT;
  assign empty  = cnt == '0;

  assign pad_bus.cmd_valid  = arb_bus.cmd_valid & ~is_int & ~full;  // stall when full
  assign pad_bus.cmd_addr   = arb_bus.cmd_addr;
  assign pad_bus.cmd_read   = arb_bus.cmd_read;
  assign pad_bus.cmd_wdata  = arb_bus.cmd_wdata;
  assign pad_bus.cmd_wmask  = arb_bus.cmd_wmask;

  assign int_bus.cmd_valid  = arb_bus.cmd_valid & is_int & ~full;
  assign int_bus.cmd_addr   = arb_bus.cmd_addr;
  assign int_bus.cmd_read   = arb_bus.cmd_read;
  assign int_bus.cmd_wdata  = arb_bus.cmd_wdata;
  assign int_bus.cmd_wmask  = arb_bus.cmd_wmask;

  assign arb_bus.cmd_ready = ~full & (is_int ? int_bus.cmd_ready : pad_bus.cmd_ready);

  assign push    = arb_bus.cmd_valid & arb_bus.cmd_ready;
  assign cmd_tgt = is_int ? TGT_INT : (arb_bus.cmd_read ? TGT_PAD_READ : TGT_PAD_WRITE);

  // ---------------------------------------------------------------------
  // order queues
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      master_q[wr_ptr] <= arb_bus.cmd_master;
      tgt_q[wr_ptr]    <= cmd_tgt;
    end
  end

  // ---------------------------------------------------------------------
  // response select
  // ---------------------------------------------------------------------
  assign head_tgt = tgt_q[rd_ptr];

  assign pad_bus.rsp_ready = ~empty & (head_tgt != TGT_INT);  // only the head may answer
  assign pad_bus.rsp_read  = ~empty & (head_tgt == TGT_PAD_READ);
  assign int_bus.rsp_ready = ~empty & (head_tgt == TGT_INT);

  assign pad_acc = pad_bus.rsp_valid & pad_bus.rsp_ready;
  assign int_acc = int_bus.rsp_valid & int_bus.rsp_ready;
  assign pop     = pad_acc | int_acc;

  assign arb_bus.rsp_valid  = pop;
  assign arb_bus.rsp_rdata  = int_acc ? int_bus.rsp_rdata : pad_bus.rsp_rdata;
  assign arb_bus.rsp_err    = int_acc ? int_bus.rsp_err : pad_bus.rsp_err;
  assign arb_bus.rsp_master = master_q[rd_ptr];

  // count and pointers move together
  a_cnt_ptrs: assert property (@(posedge clk) disable iff (!rstn)
    cnt[PTR_W-1:0] == wr_ptr - rd_ptr);

  // targets only answer commands they were given
  a_no_stray_rsp: assert property (@(posedge clk) disable iff (!rstn)
    empty |-> !pad_bus.rsp_valid && !int_bus.rsp_valid);

endmodule

`default_nettype wire

// File: hw/biu_axi_bridge.sv
/*
 * ICB to AXI bridge
 * single-beat AR, AW and W issue with R and B return
 */
`default_nettype none

module biu_axi_bridge (
  biu_icb_if.responder               pad_bus,
  output logic                       axi_ar_valid,
  input  wire logic                  axi_ar_ready,
  output biu_icb_pkg::addr_t         axi_ar_addr,
  input  wire logic                  axi_r_valid,
  output logic                       axi_r_ready,
  input  wire biu_icb_pkg::data_t    axi_r_data,
  input  wire biu_ext_pkg::axi_resp_e axi_r_resp,
  output logic                       axi_aw_valid,
  input  wire logic                  axi_aw_ready,
  output biu_icb_pkg::addr_t         axi_aw_addr,
  output logic                       axi_w_valid,
  input  wire logic                  axi_w_ready,
  output biu_icb_pkg::data_t         axi_w_data,
  output biu_icb_pkg::mask_t         axi_w_strb,
  input  wire logic                  axi_b_valid,
  output logic                       axi_b_ready,
  input  wire biu_ext_pkg::axi_resp_e axi_b_resp
);

  // command side
  assign axi_ar_valid = pad_bus.cmd_valid & pad_bus.cmd_read;
  assign axi_ar_addr  = pad_bus.cmd_addr;
  assign axi_aw_valid = pad_bus.cmd_valid & ~pad_bus.cmd_read;
  assign axi_aw_addr  = pad_bus.cmd_addr;
  assign axi_w_valid  = axi_aw_valid;        // address and data go together
  assign axi_w_data   = pad_bus.cmd_wdata;
  assign axi_w_strb   = pad_bus.cmd_wmask;

  assign pad_bus.cmd_ready = pad_bus.cmd_read ? axi_ar_ready : (axi_aw_ready & axi_w_ready);

  // response side follows the queue head kind
  assign pad_bus.rsp_valid  = pad_bus.rsp_read ? axi_r_valid : axi_b_valid;
  assign axi_r_ready        = pad_bus.rsp_ready & pad_bus.rsp_read;
  assign axi_b_ready        = pad_bus.rsp_ready & ~pad_bus.rsp_read;
  assign pad_bus.rsp_rdata  = axi_r_data;
  assign pad_bus.rsp_err    = pad_bus.rsp_read ? axi_r_resp[1] : axi_b_resp[1];  // slverr or decerr

endmodule

`default_nettype wire

// File: hw/biu_ahb_bridge.sv
/*
 * ICB to AHB-lite bridge for the interrupt controller
 * single NONSEQ transfers with mask based lane steering
 * data phase tracking and a held response until the queue takes it
 */
`include "biu_cfg.svh"
`default_nettype none

module biu_ahb_bridge (
  input  wire logic               clk,
  input  wire logic               rstn,
  biu_icb_if.responder            int_bus,
  input  wire logic               int_hreadyout,
  input  wire logic               int_hresp,
  input  wire biu_icb_pkg::data_t int_hrdata,
  output biu_ext_pkg::htrans_e    int_htrans,
  output biu_icb_pkg::addr_t      int_haddr,
  output logic                    int_hwrite,
  output biu_icb_pkg::data_t      int_hwdata,
  output logic                    int_hready
);
  import biu_icb_pkg::*;
  import biu_ext_pkg::*;

  localparam int HALF = `BIU_DATA_W / 2;

  logic  cmd_fire;
  logic  rsp_capture;
  logic  data_phase;   // transfer issued and waiting on hreadyout
  logic  rsp_held;
  logic  rsp_err_q;
  data_t rsp_rdata_q;
  data_t lane_data;

  // ---------------------------------------------------------------------
  // address phase
  // ---------------------------------------------------------------------
  assign int_bus.cmd_ready = int_hreadyout & ~rsp_held & ~data_phase;  // one at a time
  assign cmd_fire          = int_bus.cmd_valid & int_bus.cmd_ready;

  assign int_htrans = cmd_fire ? HTRANS_NONSEQ : HTRANS_IDLE;
  assign int_haddr  = int_bus.cmd_addr;
  assign int_hwrite = ~int_bus.cmd_read;
  assign int_hready = int_hreadyout;

  always_comb begin
    case (int_bus.cmd_wmask)
      8'hff:   lane_data = int_bus.cmd_wdata;
      8'hf0:   lane_data = {int_bus.cmd_wdata[`BIU_DATA_W-1 -: HALF], {HALF{1'b0}}};
      8'h0f:   lane_data = {{HALF{1'b0}}, int_bus.cmd_wdata[HALF-1:0]};
      default: lane_data = '0;  // partial words not supported
    endcase
  end

  assign int_hwdata = lane_data;  // driven with the address

  // ---------------------------------------------------------------------
  // data phase and held response
  // ---------------------------------------------------------------------
  assign rsp_capture = data_phase & int_hreadyout;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      data_phase <= 1'b0;
      rsp_held   <= 1'b0;
    end else begin
      if (cmd_fire) data_phase <= 1'b1;
      else if (rsp_capture) data_phase <= 1'b0;
      if (rsp_capture) rsp_held <= 1'b1;
      else if (int_bus.rsp_ready) rsp_held <= 1'b0;  // head took it
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_capture) begin
      rsp_rdata_q <= int_hrdata;
      rsp_err_q   <= int_hresp;
    end
  end

  assign int_bus.rsp_valid  = rsp_held;
  assign int_bus.rsp_rdata  = rsp_rdata_q;
  assign int_bus.rsp_err    = rsp_err_q;

  // slave stretches only a data phase
  a_ready_outside_data: assert property (@(posedge clk) disable iff (!rstn)
    !data_phase |-> int_hreadyout);

endmodule

`default_nettype wire

// File: hw/biu_top.sv
/*
 * BIU top level
 * jtag and lsu ICB ports, AXI pad port, AHB-lite interrupt port
 */
`include "biu_cfg.svh"
`default_nettype none

module biu_top (
  input  wire logic                     clk,
  input  wire logic                     rstn,
  // jtag
  input  wire logic                     jtag_cmd_valid,
  output logic                          jtag_cmd_ready,
  input  wire biu_icb_pkg::addr_t       jtag_cmd_addr,
  input  wire logic                     jtag_cmd_read,
  input  wire logic [`BIU_JTAG_W-1:0]   jtag_cmd_wdata,
  input  wire logic [`BIU_JTAG_W/8-1:0] jtag_cmd_wmask,
  output logic                          jtag_rsp_valid,
  output logic [`BIU_JTAG_W-1:0]        jtag_rsp_rdata,
  output logic                          jtag_rsp_err,
  // lsu
  input  wire logic                     lsu_cmd_valid,
  output logic                          lsu_cmd_ready,
  input  wire biu_icb_pkg::addr_t       lsu_cmd_addr,
  input  wire logic                     lsu_cmd_read,
  input  wire biu_icb_pkg::data_t       lsu_cmd_wdata,
  input  wire biu_icb_pkg::mask_t       lsu_cmd_wmask,
  output logic                          lsu_rsp_valid,
  output biu_icb_pkg::data_t            lsu_rsp_rdata,
  output logic                          lsu_rsp_err,
  // axi pad
  output logic                          axi_ar_valid,
  input  wire logic                     axi_ar_ready,
  output biu_icb_pkg::addr_t            axi_ar_addr,
  input  wire logic                     axi_r_valid,
  output logic                          axi_r_ready,
  input  wire biu_icb_pkg::data_t       axi_r_data,
  input  wire biu_ext_pkg::axi_resp_e   axi_r_resp,
  output logic                          axi_aw_valid,
  input  wire logic                     axi_aw_ready,
  output biu_icb_pkg::addr_t            axi_aw_addr,
  output logic                          axi_w_valid,
  input  wire logic                     axi_w_ready,
  output biu_icb_pkg::data_t            axi_w_data,
  output biu_icb_pkg::mask_t            axi_w_strb,
  input  wire logic                     axi_b_valid,
  output logic                          axi_b_ready,
  input  wire biu_ext_pkg::axi_resp_e   axi_b_resp,
  // ahb interrupt controller
  input  wire logic                     int_hreadyout,
  input  wire logic                     int_hresp,
  input  wire biu_icb_pkg::data_t       int_hrdata,
  output biu_ext_pkg::htrans_e          int_htrans,
  output biu_icb_pkg::addr_t            int_haddr,
  output logic                          int_hwrite,
  output biu_icb_pkg::data_t            int_hwdata,
  output logic                          int_hready
);

  biu_icb_if arb_bus ();  // arbiter to order ctrl
  biu_icb_if pad_bus ();  // order ctrl to axi bridge
  biu_icb_if int_bus ();  // order ctrl to ahb bridge

  // ports connect by name
  biu_arb        u_arb        (.*);
  biu_order_ctrl u_order_ctrl (.*);
  biu_axi_bridge u_axi_bridge (.*);
  biu_ahb_bridge u_ahb_bridge (.*);

endmodule

`default_nettype wire

// File: test/tb_biu_slaves.sv
/*
 * memory models behind the BIU
 * AXI slave with one outstanding read and one outstanding write
 * AHB-lite slave answering in its data phase
 * bit 20 of the address selects the error region
 */
`default_nettype none

module tb_biu_slaves (
  input  wire logic                   clk,
  input  wire logic                   rstn,
  // axi pad side
  input  wire logic                   axi_ar_valid,
  output logic                        axi_ar_ready,
  input  wire biu_icb_pkg::addr_t     axi_ar_addr,
  output logic                        axi_r_valid,
  input  wire logic                   axi_r_ready,
  output biu_icb_pkg::data_t          axi_r_data,
  output biu_ext_pkg::axi_resp_e      axi_r_resp,
  input  wire logic                   axi_aw_valid,
  output logic                        axi_aw_ready,
  input  wire biu_icb_pkg::addr_t     axi_aw_addr,
  input  wire logic                   axi_w_valid,
  output logic                        axi_w_ready,
  input  wire biu_icb_pkg::data_t     axi_w_data,
  input  wire biu_icb_pkg::mask_t     axi_w_strb,
  output logic                        axi_b_valid,
  input  wire logic                   axi_b_ready,
  output biu_ext_pkg::axi_resp_e      axi_b_resp,
  // ahb interrupt controller side
  input  wire biu_ext_pkg::htrans_e   int_htrans,
  input  wire biu_icb_pkg::addr_t     int_haddr,
  input  wire logic                   int_hwrite,
  input  wire biu_icb_pkg::data_t     int_hwdata,
  input  wire logic                   int_hready,
  output logic                        int_hreadyout,
  output logic                        int_hresp,
  output biu_icb_pkg::data_t          int_hrdata
);
  timeunit 1ns;
  timeprecision 1ps;
  import biu_icb_pkg::*;
  import biu_ext_pkg::*;

  localparam int WORDS = 64;
  localparam int ERR_BIT = 20;  // error region select

  data_t axi_mem [WORDS];
  data_t ahb_mem [WORDS];

  function automatic logic [5:0] word_idx(input addr_t a);
    return a[8:3];  // 64-bit words
  endfunction

  // ------------------------------------------------------------------
  // axi memory
  // ------------------------------------------------------------------
  assign axi_ar_ready = ~axi_r_valid;  // one read at a time
  assign axi_aw_ready = ~axi_b_valid;
  assign axi_w_ready  = ~axi_b_valid;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      axi_r_valid <= 1'b0;
      axi_r_data  <= '0;
      axi_r_resp  <= OKAY;
      axi_b_valid <= 1'b0;
      axi_b_resp  <= OKAY;
      for (int i = 0; i < WORDS; i++) begin
        axi_mem[i] <= '0;
      end
    end else begin
      if (axi_ar_valid && axi_ar_ready) begin
        axi_r_valid <= 1'b1;  // answer one cycle after the address
        axi_r_data  <= axi_ar_addr[ERR_BIT] ? '0 : axi_mem[word_idx(axi_ar_addr)];
        axi_r_resp  <= axi_ar_addr[ERR_BIT] ? SLVERR : OKAY;
      end else if (axi_r_ready) begin
        axi_r_valid <= 1'b0;
      end
      if (axi_aw_valid && axi_aw_ready && axi_w_valid && axi_w_ready) begin
        axi_b_valid <= 1'b1;
        axi_b_resp  <= axi_aw_addr[ERR_BIT] ? SLVERR : OKAY;
        for (int b = 0; b < 8; b++) begin
          if (axi_w_strb[b] && !axi_aw_addr[ERR_BIT]) begin
            axi_mem[word_idx(axi_aw_addr)][8*b +: 8] <= axi_w_data[8*b +: 8];  // byte strobe
          end
        end
      end else if (axi_b_ready) begin
        axi_b_valid <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------
  // ahb memory
  // ------------------------------------------------------------------
  assign int_hreadyout = 1'b1;  // zero wait states

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      int_hresp  <= 1'b0;
      int_hrdata <= '0;
      for (int i = 0; i < WORDS; i++) begin
        ahb_mem[i] <= '0;
      end
    end else begin
      int_hresp  <= 1'b0;  // only high in an error data phase
      int_hrdata <= '0;
      if (int_htrans == HTRANS_NONSEQ && int_hready) begin
        if (int_haddr[ERR_BIT]) begin
          int_hresp <= 1'b1;
        end else if (int_hwrite) begin
          ahb_mem[word_idx(int_haddr)] <= int_hwdata;  // lanes already steered
        end else begin
          int_hrdata <= ahb_mem[word_idx(int_haddr)];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_biu.sv
/*
 * BIU testbench top
 * clock, reset, stimulus table with in-order response checks
 * watchdog and final result
 */
`include "biu_cfg.svh"
`default_nettype none

module tb_biu;
  timeunit 1ns;
  timeprecision 1ps;
  import biu_icb_pkg::*;
  import biu_ext_pkg::*;

  localparam int SEED            = 32'h30f;
  localparam int CYCLES_PER_TEST = 50;

  typedef struct {
    string   name;
    master_e master;
    logic    read;
    addr_t   addr;
    data_t   wdata;
    mask_t   wmask;
    data_t   exp_rdata;
    logic    exp_err;
    logic    pair;       // issued in the same cycle as the next entry
  } entry_t;

  logic clk;
  logic rstn;
  logic jtag_cmd_valid, jtag_cmd_ready, jtag_cmd_read, jtag_rsp_valid, jtag_rsp_err;
  addr_t jtag_cmd_addr;
  logic [`BIU_JTAG_W-1:0] jtag_cmd_wdata, jtag_rsp_rdata;
  logic [`BIU_JTAG_W/8-1:0] jtag_cmd_wmask;
  logic lsu_cmd_valid, lsu_cmd_ready, lsu_cmd_read, lsu_rsp_valid, lsu_rsp_err;
  addr_t lsu_cmd_addr;
  data_t lsu_cmd_wdata, lsu_rsp_rdata;
  mask_t lsu_cmd_wmask;
  logic axi_ar_valid, axi_ar_ready, axi_r_valid, axi_r_ready;
  logic axi_aw_valid, axi_aw_ready, axi_w_valid, axi_w_ready, axi_b_valid, axi_b_ready;
  addr_t axi_ar_addr, axi_aw_addr;
  data_t axi_r_data, axi_w_data;
  mask_t axi_w_strb;
  axi_resp_e axi_r_resp, axi_b_resp;
  logic int_hreadyout, int_hresp, int_hwrite, int_hready;
  data_t int_hrdata, int_hwdata;
  addr_t int_haddr;
  htrans_e int_htrans;

  entry_t tests [$];
  int     inflight_q [$];  // table index per issued command
  int     jtag_idx;
  int     lsu_idx;
  logic   jtag_pend;
  logic   lsu_pend;

  biu_top biu_top_inst (.*);
  tb_biu_slaves slaves (.*);

  // ------------------------------------------------------------------
  // clock and watchdog
  // ------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    @(posedge rstn);
    repeat (CYCLES_PER_TEST * tests.size()) @(posedge clk);
    $display("watchdog expired, the DUT stopped answering");
    abort_run();
  end

  // ------------------------------------------------------------------
  // check helpers
  // ------------------------------------------------------------------
  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_htrans(input string name, input htrans_e exp, input htrans_e act);
    if (act !== exp) begin
      $display("ERR %s expected %s actual %s", name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic add_entry(input string name, input master_e m, input logic rd,
                           input addr_t a, input data_t wd, input mask_t wm,
                           input data_t exp, input logic err, input logic pair);
    entry_t e;
    e = '{name, m, rd, a, wd, wm, exp, err, pair};
    tests.push_back(e);
  endtask

  // expected values follow the BIU rules, not the DUT
  task automatic build_table();
    data_t       w0;
    data_t       w1;
    data_t       w2;
    logic [31:0] w3;
    w0 = {$urandom, $urandom};
    w1 = {$urandom, $urandom};
    w2 = {$urandom, $urandom};
    w3 = $urandom;
    add_entry("lsu_pad_write", MASTER_LSU, 1'b0, 32'h0000_0040, w0, 8'hff, '0, 1'b0, 1'b0);
    add_entry("lsu_pad_read", MASTER_LSU, 1'b1, 32'h0000_0040, '0, '0, w0, 1'b0, 1'b0);
    add_entry("jtag_pad_read", MASTER_JTAG, 1'b1, 32'h0000_0040, '0, '0,
              {32'h0, w0[31:0]}, 1'b0, 1'b0);                         // low word only
    add_entry("lsu_int_write_f0", MASTER_LSU, 1'b0, 32'h9000_0080, w1, 8'hf0, '0, 1'b0, 1'b0);
    add_entry("lsu_int_read", MASTER_LSU, 1'b1, 32'h9000_0080, '0, '0,
              {w1[63:32], 32'h0}, 1'b0, 1'b0);                        // high lanes kept
    add_entry("lsu_pad_err_read", MASTER_LSU, 1'b1, 32'h0010_0000, '0, '0, '0, 1'b1, 1'b0);
    add_entry("lsu_int_err_read", MASTER_LSU, 1'b1, 32'h9010_0000, '0, '0, '0, 1'b1, 1'b0);
    add_entry("lsu_pad_write_b", MASTER_LSU, 1'b0, 32'h0000_0088, w2, 8'hff, '0, 1'b0, 1'b0);
    add_entry("jtag_pad_write", MASTER_JTAG, 1'b0, 32'h0000_00c0, {32'h0, w3}, 8'h0f, '0,
              1'b0, 1'b0);
    add_entry("jtag_pair_read", MASTER_JTAG, 1'b1, 32'h0000_00c0, '0, '0, {32'h0, w3},
              1'b0, 1'b1);                                             // same cycle as lsu
    add_entry("lsu_pair_read", MASTER_LSU, 1'b1, 32'h0000_0088, '0, '0, w2, 1'b0, 1'b0);
  endtask

  task automatic check_reset_state();
    check_flag("reset_jtag_rsp_valid", 1'b0, jtag_rsp_valid);
    check_flag("reset_lsu_rsp_valid", 1'b0, lsu_rsp_valid);
    check_flag("reset_axi_ar_valid", 1'b0, axi_ar_valid);
    check_flag("reset_axi_aw_valid", 1'b0, axi_aw_valid);
    check_flag("reset_axi_w_valid", 1'b0, axi_w_valid);
    check_flag("reset_axi_r_ready", 1'b0, axi_r_ready);
    check_flag("reset_axi_b_ready", 1'b0, axi_b_ready);
    check_htrans("reset_int_htrans", HTRANS_IDLE, int_htrans);
  endtask

  // ------------------------------------------------------------------
  // command drive and response collection
  // ------------------------------------------------------------------
  task automatic drive_cmd(input int idx);
    entry_t e;
    e = tests[idx];
    if (e.master == MASTER_JTAG) begin
      jtag_cmd_valid <= 1'b1;
      jtag_cmd_addr  <= e.addr;
      jtag_cmd_read  <= e.read;
      jtag_cmd_wdata <= e.wdata[`BIU_JTAG_W-1:0];
      jtag_cmd_wmask <= e.wmask[`BIU_JTAG_W/8-1:0];
      jtag_idx  = idx;
      jtag_pend = 1'b1;
    end else begin
      lsu_cmd_valid <= 1'b1;
      lsu_cmd_addr  <= e.addr;
      lsu_cmd_read  <= e.read;
      lsu_cmd_wdata <= e.wdata;
      lsu_cmd_wmask <= e.wmask;
      lsu_idx  = idx;
      lsu_pend = 1'b1;
    end
  endtask

  // holds valid until the handshake, sampled away from the edge
  task automatic issue_pending();
    logic jtag_fire;
    logic lsu_fire;
    while (jtag_pend || lsu_pend) begin
      @(negedge clk);
      jtag_fire = jtag_cmd_valid && jtag_cmd_ready;
      lsu_fire  = lsu_cmd_valid && lsu_cmd_ready;
      if (lsu_fire && jtag_pend) begin
        $display("lsu command was accepted while a jtag command was still waiting");
        abort_run();
      end
      @(posedge clk);
      if (jtag_fire) begin
        jtag_cmd_valid <= 1'b0;
        jtag_pend = 1'b0;
        inflight_q.push_back(jtag_idx);
      end
      if (lsu_fire) begin
        lsu_cmd_valid <= 1'b0;
        lsu_pend = 1'b0;
        inflight_q.push_back(lsu_idx);
      end
    end
  endtask

  task automatic take_response(input master_e m, input data_t rdata, input logic err);
    int idx;
    if (inflight_q.size() == 0) begin
      $display("a response arrived with no command in flight");
      abort_run();
    end
    idx = inflight_q.pop_front();  // oldest command answers first
    if (tests[idx].master != m) begin
      $display("response to %s went to the wrong master or out of order", tests[idx].name);
      abort_run();
    end
    if (tests[idx].read) begin
      check_data(tests[idx].name, tests[idx].exp_rdata, rdata);
    end
    check_flag(tests[idx].name, tests[idx].exp_err, err);
  endtask

  always @(negedge clk) begin
    if (rstn && jtag_rsp_valid) begin
      take_response(MASTER_JTAG, data_t'(jtag_rsp_rdata), jtag_rsp_err);
    end
    if (rstn && lsu_rsp_valid) begin
      take_response(MASTER_LSU, lsu_rsp_rdata, lsu_rsp_err);
    end
  end

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    int i;
    void'($urandom(SEED));
    rstn           = 1'b0;
    jtag_cmd_valid = 1'b0;
    jtag_cmd_addr  = '0;
    jtag_cmd_read  = 1'b0;
    jtag_cmd_wdata = '0;
    jtag_cmd_wmask = '0;
    lsu_cmd_valid  = 1'b0;
    lsu_cmd_addr   = '0;
    lsu_cmd_read   = 1'b0;
    lsu_cmd_wdata  = '0;
    lsu_cmd_wmask  = '0;
    jtag_pend      = 1'b0;
    lsu_pend       = 1'b0;
    build_table();
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check_reset_state();
    i = 0;
    while (i < tests.size()) begin
      @(posedge clk);
      drive_cmd(i);
      if (tests[i].pair) begin
        drive_cmd(i + 1);
        i++;
      end
      i++;
      issue_pending();
      while (inflight_q.size() != 0) begin
        @(negedge clk);
      end
    end
    @(negedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: biu.f
+incdir+hw
hw/biu_icb_pkg.sv
hw/biu_ext_pkg.sv
hw/biu_icb_if.sv
hw/biu_arb.sv
hw/biu_order_ctrl.sv
hw/biu_axi_bridge.sv
hw/biu_ahb_bridge.sv
hw/biu_top.sv
test/tb_biu_slaves.sv
test/tb_biu.sv

// File: Makefile
# Verilator build and run of the BIU testbench

VERILATOR ?= verilator
TOP       ?= tb_biu
FILELIST  ?= biu.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)

SOURCES := $(FILELIST) $(wildcard hw/*.sv hw/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
